/* sources.f */
+incdir+src
src/exp_pkg.sv
src/exp_lut_pipe.sv
src/frac_frame_buf.sv
src/frac_to_fp32.sv
src/fp32_axis_out.sv
src/exp_frame_top.sv
dv/clk_rst_gen.sv
dv/exp_frame_assert.sv
dv/tb_exp_frame.sv

/* Makefile */
SIM := obj_dir/Vtb_exp_frame

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM) +verilator+error+limit+1000); echo "$$out"; \
	echo "$$out" | grep -qx 'Regression passed'

$(SIM): sources.f $(wildcard src/*.sv src/*.svh dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_exp_frame -f sources.f

clean:
	rm -rf obj_dir

/* dv/tb_exp_frame.sv */
`timescale 1ns/100ps
`include "exp_cfg.svh"

module tb_exp_frame
    import exp_pkg::*;
();

    localparam int CYCLE_LIMIT = 6 * (`EXP_LUT_N + `FRAME_DEPTH * 19 + 40);

    logic           clock;
    logic           reset_n;
    exp_in_t        sample;
    logic           sample_valid;
    logic           frame_done;
    logic           axis_ready;
    logic           axis_valid;
    logic           axis_last;
    fp32_t          axis_data;

    logic [31:0]    data_lfsr = 32'h8585_1bdc;
    logic [31:0]    rdy_lfsr  = 32'h8585_1bdc;
    exp_in_t        directed_q[$];
    fp32_t          exp_fp_q[$];            // expected beats in order
    int             exp_len_q[$];           // nonzero frame lengths
    int             beat_idx  = 0;
    int             beat_cnt  = 0;
    int             err_cnt   = 0;
    int             cycle_cnt = 0;

    clk_rst_gen u_clk (
        .clock_o    (clock),
        .reset_n_o  (reset_n)
    );

    exp_frame_top dut0 (
        .clock_i        (clock),
        .reset_n_i      (reset_n),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .frame_done_i   (frame_done),
        .m_axis_ready_i (axis_ready),
        .m_axis_valid_o (axis_valid),
        .m_axis_last_o  (axis_last),
        .m_axis_data_o  (axis_data)
    );

    bind exp_frame_top exp_frame_assert u_assert (
        .clock_i        (clock_i),
        .reset_n_i      (reset_n_i),
        .frame_done_i   (frame_done_i),
        .ready_i        (m_axis_ready_i),
        .valid_i        (m_axis_valid_o),
        .last_i         (m_axis_last_o),
        .data_i         (m_axis_data_o)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // taps 32 22 2 1
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            data_lfsr = lfsr_next(data_lfsr);
            v = (v << 1) | int'(data_lfsr[0]);
        end
        return v;
    endfunction

    function automatic exp_in_t random_sample();
        int mag;
        mag = take_bits(1) ? take_bits(15) : take_bits(12);  // half of them below 16.0
        if (mag == 0)
            mag = 1;
        return exp_in_t'(-mag);
    endfunction

    // e^-(2^(k-8)) truncated to 0.16
    function automatic frac_t table_const(input int k);
        real x;
        x = 1.0 / 256.0;
        for (int i = 0; i < k; i++)
            x = x * 2.0;
        return frac_t'($rtoi($exp(-x) * 65536.0));
    endfunction

    function automatic fp32_t model_exp(input exp_in_t s);
        exp_in_t    m;
        prod_t      p;
        frac_t      f;
        int         lz;
        m = -s;
        p = (m[14:12] != 3'b000) ? '0 : 32'hFFFF_0000;
        for (int b = 11; b >= 0; b--)
        begin
            if (m[b])
                p = prod_t'((64'(p) * {table_const(b), 16'h0000}) >> 32);
        end
        f = p[31:16];
        if (f == '0)
            return '0;
        lz = 0;
        while (!f[15])
        begin
            f = f << 1;
            lz++;
        end
        return {1'b0, 8'(126 - lz), f[14:0], 8'h00};
    endfunction

    task automatic send_frame(input int len, input bit done_on_last);
        exp_in_t s;
        if (len > 0)
            exp_len_q.push_back(len);
        for (int i = 0; i < len; i++)
        begin
            s = (directed_q.size() > 0) ? directed_q.pop_front() : random_sample();
            exp_fp_q.push_back(model_exp(s));
            @(posedge clock);
            sample       <= s;
            sample_valid <= 1'b1;
            frame_done   <= done_on_last && (i == len - 1);
        end
        if (!done_on_last || (len == 0))
        begin
            @(posedge clock);
            sample_valid <= 1'b0;
            frame_done   <= 1'b1;
        end
        @(posedge clock);
        sample_valid <= 1'b0;
        frame_done   <= 1'b0;
        while (!dut0.frame_clear)           // next frame waits for the stores to clear
            @(posedge clock);
    endtask

    task automatic finish_run();
        int asrt_fails;
        asrt_fails = dut0.u_assert.fail_cnt;
        $display("beats %0d, check errors %0d, assertion failures %0d",
                 beat_cnt, err_cnt, asrt_fails);
        if ((err_cnt == 0) && (asrt_fails == 0))
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    always @(posedge clock)
    begin
        rdy_lfsr = lfsr_next(rdy_lfsr);
        axis_ready <= rdy_lfsr[0];
    end

    // scoreboard on accepted beats
    always @(posedge clock)
    begin
        fp32_t  want;
        int     len;
        if (reset_n && axis_valid && axis_ready)
        begin
            beat_cnt++;
            if ((exp_fp_q.size() == 0) || (exp_len_q.size() == 0))
            begin
                err_cnt++;
                $display("beat at %0t arrived with no sample left to match it", $time);
            end
            else
            begin
                want = exp_fp_q.pop_front();
                len  = exp_len_q[0];
                assert (axis_data === want)
                else
                begin
                    err_cnt++;
                    $display("ERR %0t m_axis_data_o expected %h got %h",
                             $time, want, axis_data);
                end
                assert (axis_last === (beat_idx == len - 1))
                else
                begin
                    err_cnt++;
                    $display("ERR %0t m_axis_last_o expected %0b got %0b",
                             $time, (beat_idx == len - 1), axis_last);
                end
                if (beat_idx == len - 1)
                begin
                    beat_idx = 0;
                    void'(exp_len_q.pop_front());
                end
                else
                    beat_idx++;
            end
        end
    end

    initial
    begin
        sample       = '0;
        sample_valid = 1'b0;
        frame_done   = 1'b0;
        axis_ready   = 1'b0;
        while (reset_n !== 1'b1)
            @(posedge clock);
        repeat (3) @(posedge clock);
        directed_q.push_back(16'h0000);
        send_frame(1, 1'b0);
        directed_q.push_back(16'hF800);     // -8.0
        directed_q.push_back(16'hEF80);     // -16.5
        directed_q.push_back(16'hFFFF);     // -1/256
        send_frame(10, 1'b0);
        send_frame(3, 1'b1);
        send_frame(0, 1'b0);
        send_frame(take_bits(4) % 11, 1'b1);
        send_frame(take_bits(4) % 11, 1'b0);
        assert (exp_fp_q.size() == 0)
        else
        begin
            err_cnt++;
            $display("%0d expected beats never arrived", exp_fp_q.size());
        end
        finish_run();
    end

    initial
    begin
        while (cycle_cnt < CYCLE_LIMIT)
        begin
            @(posedge clock);
            cycle_cnt++;
        end
        err_cnt++;
        $display("timeout after %0d cycles, frames did not complete", cycle_cnt);
        finish_run();
    end

endmodule

/* dv/exp_frame_assert.sv */
`timescale 1ns/100ps
`include "exp_cfg.svh"

module exp_frame_assert
    import exp_pkg::*;
(
    input  logic    clock_i,
    input  logic    reset_n_i,
    input  logic    frame_done_i,
    input  logic    ready_i,
    input  logic    valid_i,
    input  logic    last_i,
    input  fp32_t   data_i
);

    int     fail_cnt = 0;
    logic   done_seen;                      // first frame_done has arrived

    always_ff @(posedge clock_i)
    begin
        if (!reset_n_i)
            done_seen <= 1'b0;
        else if (frame_done_i)
            done_seen <= 1'b1;
    end

    quiet_after_reset: assert property (@(posedge clock_i) disable iff (!reset_n_i)
        !done_seen |-> !valid_i && !last_i)
    else
    begin
        fail_cnt++;
        $error("stream active before the first frame ended");
    end

    // AXI4-Stream stall rule
    hold_on_stall: assert property (@(posedge clock_i) disable iff (!reset_n_i)
        valid_i && !ready_i |=> valid_i && $stable(data_i) && $stable(last_i))
    else
    begin
        fail_cnt++;
        $error("beat changed while stalled");
    end

    float_range: assert property (@(posedge clock_i) disable iff (!reset_n_i)
        valid_i && (data_i != '0) |-> !data_i[31] && (data_i[30:23] <= 8'd126))
    else
    begin
        fail_cnt++;
        $error("float beat negative or not below 1.0");
    end

    last_with_valid: assert property (@(posedge clock_i) disable iff (!reset_n_i)
        last_i |-> valid_i)
    else
    begin
        fail_cnt++;
        $error("last high without valid");
    end

endmodule

/* dv/clk_rst_gen.sv */
`timescale 1ns/100ps

module clk_rst_gen
(
    output logic    clock_o,
    output logic    reset_n_o
);

    initial
    begin
        clock_o   = 1'b0;
        reset_n_o = 1'b0;
        repeat (4) @(posedge clock_o);
        reset_n_o <= 1'b1;
    end

    always #10 clock_o = ~clock_o;  // 20 ns period

endmodule

/* src/exp_frame_top.sv */
`timescale 1ns/100ps
`include "exp_cfg.svh"

module exp_frame_top
    import exp_pkg::*;
(
    input  logic        clock_i,
    input  logic        reset_n_i,
    input  exp_in_t     sample_i,
    input  logic        sample_valid_i,
    input  logic        frame_done_i,
    input  logic        m_axis_ready_i,
    output logic        m_axis_valid_o,
    output logic        m_axis_last_o,
    output fp32_t       m_axis_data_o
);

    frac_t          lut_frac;
    logic           lut_valid;
    logic           lut_done;
    frame_idx_t     frame_len;
    logic           frame_ready;
    frame_idx_t     rd_idx;
    frac_t          rd_frac;
    frame_idx_t     out_idx;
    fp32_t          out_fp;
    logic           conv_done;
    logic           frame_clear;

    exp_lut_pipe u_lut_pipe (
        .clock_i        (clock_i),
        .reset_n_i      (reset_n_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .frame_done_i   (frame_done_i),
        .lut_frac_o     (lut_frac),
        .lut_valid_o    (lut_valid),
        .lut_done_o     (lut_done)
    );

    frac_frame_buf u_frac_buf (
        .clock_i        (clock_i),
        .reset_n_i      (reset_n_i),
        .lut_frac_i     (lut_frac),
        .lut_valid_i    (lut_valid),
        .lut_done_i     (lut_done),
        .frame_clear_i  (frame_clear),
        .rd_idx_i       (rd_idx),
        .rd_frac_o      (rd_frac),
        .frame_len_o    (frame_len),
        .frame_ready_o  (frame_ready)
    );

    frac_to_fp32 u_to_fp32 (
        .clock_i        (clock_i),
        .reset_n_i      (reset_n_i),
        .rd_frac_i      (rd_frac),
        .frame_len_i    (frame_len),
        .frame_ready_i  (frame_ready),
        .frame_clear_i  (frame_clear),
        .out_idx_i      (out_idx),
        .rd_idx_o       (rd_idx),
        .out_fp_o       (out_fp),
        .conv_done_o    (conv_done)
    );

    fp32_axis_out u_axis_out (
        .clock_i        (clock_i),
        .reset_n_i      (reset_n_i),
        .out_fp_i       (out_fp),
        .frame_len_i    (frame_len),
        .conv_done_i    (conv_done),
        .m_axis_ready_i (m_axis_ready_i),
        .out_idx_o      (out_idx),
        .frame_clear_o  (frame_clear),
        .m_axis_valid_o (m_axis_valid_o),
        .m_axis_last_o  (m_axis_last_o),
        .m_axis_data_o  (m_axis_data_o)
    );

endmodule

/* src/fp32_axis_out.sv */
`timescale 1ns/100ps
`include "exp_cfg.svh"

module fp32_axis_out
    import exp_pkg::*;
(
    input  logic        clock_i,
    input  logic        reset_n_i,
    input  fp32_t       out_fp_i,
    input  frame_idx_t  frame_len_i,
    input  logic        conv_done_i,
    input  logic        m_axis_ready_i,
    output frame_idx_t  out_idx_o,
    output logic        frame_clear_o,
    output logic        m_axis_valid_o,
    output logic        m_axis_last_o,
    output fp32_t       m_axis_data_o
);

    out_state_t     state;
    logic           load_word;
    logic           beat_done;

    assign beat_done = m_axis_valid_o && m_axis_ready_i;

    // next word goes out at start of frame or after an accepted non-last beat
    assign load_word = ((state == OUT_IDLE) && conv_done_i && (frame_len_i != '0)) ||
                       ((state == OUT_SEND) && beat_done && !m_axis_last_o);

    always_ff @(posedge clock_i)
    begin
        if (load_word)
        begin
            m_axis_data_o <= out_fp_i;
        end
    end

    always_ff @(posedge clock_i)
    begin
        if (!reset_n_i)
        begin
            state          <= OUT_IDLE;
            out_idx_o      <= '0;
            frame_clear_o  <= 1'b0;
            m_axis_valid_o <= 1'b0;
            m_axis_last_o  <= 1'b0;
        end
        else
        begin
            frame_clear_o <= 1'b0;
            if (load_word)
            begin
                m_axis_valid_o <= 1'b1;
                m_axis_last_o  <= (out_idx_o == frame_len_i - 1'b1);
                out_idx_o      <= out_idx_o + 1'b1;
            end
            case (state)
                OUT_IDLE:
                begin
                    if (conv_done_i)
                    begin
                        if (frame_len_i == '0)
                        begin
                            frame_clear_o <= 1'b1;  // empty frame
                            state         <= OUT_DONE;
                        end
                        else
                            state <= OUT_SEND;
                    end
                end
                OUT_SEND:
                begin
                    if (beat_done && m_axis_last_o)
                    begin
                        m_axis_valid_o <= 1'b0;
                        m_axis_last_o  <= 1'b0;
                        frame_clear_o  <= 1'b1;
                        state          <= OUT_DONE;
                    end
                end
                default:
                begin
                    out_idx_o <= '0;                // stores clear this cycle
                    state     <= OUT_IDLE;
                end
            endcase
        end
    end

endmodule

/* src/frac_to_fp32.sv */
`timescale 1ns/100ps
`include "exp_cfg.svh"

module frac_to_fp32
    import exp_pkg::*;
(
    input  logic        clock_i,
    input  logic        reset_n_i,
    input  frac_t       rd_frac_i,
    input  frame_idx_t  frame_len_i,
    input  logic        frame_ready_i,
    input  logic        frame_clear_i,
    input  frame_idx_t  out_idx_i,
    output frame_idx_t  rd_idx_o,
    output fp32_t       out_fp_o,
    output logic        conv_done_o
);

    cvt_state_t     state;
    frame_idx_t     cnt;
    frac_t          sh;                     // fraction being normalized
    logic [7:0]     exp_q;
    fp32_t          fp_word;
    fp32_t          fp_mem [`FRAME_DEPTH];

    always_ff @(posedge clock_i)
    begin
        if (!reset_n_i || frame_clear_i)
        begin
            state       <= CVT_IDLE;
            cnt         <= '0;
            conv_done_o <= 1'b0;
        end
        else
        begin
            case (state)
                CVT_IDLE:
                begin
                    if (frame_ready_i && !conv_done_o)
                    begin
                        if (cnt == frame_len_i)
                            conv_done_o <= 1'b1;
                        else
                            state <= CVT_LOAD;
                    end
                end
                CVT_LOAD:
                    state <= CVT_SHIFT;
                CVT_SHIFT:
                begin
                    if ((sh == '0) || sh[`EXP_FRAC_W-1])
                        state <= CVT_WRITE;
                end
                default:
                begin
                    cnt   <= cnt + 1'b1;
                    state <= CVT_IDLE;
                end
            endcase
        end
    end

    // normalizer datapath
    always_ff @(posedge clock_i)
    begin
        if (state == CVT_LOAD)
        begin
            sh    <= rd_frac_i;
            exp_q <= `FP_EXP_START;
        end
        else if ((state == CVT_SHIFT) && (sh != '0) && !sh[`EXP_FRAC_W-1])
        begin
            sh    <= sh << 1;
            exp_q <= exp_q - 1'b1;
        end
    end

    // hidden bit dropped, low mantissa bits always zero
    assign fp_word = (sh == '0) ? '0 : {1'b0, exp_q, sh[`EXP_FRAC_W-2:0], 8'b0};

    always_ff @(posedge clock_i)
    begin
        if (state == CVT_WRITE)
        begin
            fp_mem[cnt] <= fp_word;
        end
    end

    assign rd_idx_o = cnt;
    assign out_fp_o = fp_mem[out_idx_i];

endmodule

/* src/frac_frame_buf.sv */
`timescale 1ns/100ps
`include "exp_cfg.svh"

module frac_frame_buf
    import exp_pkg::*;
(
    input  logic        clock_i,
    input  logic        reset_n_i,
    input  frac_t       lut_frac_i,
    input  logic        lut_valid_i,
    input  logic        lut_done_i,
    input  logic        frame_clear_i,
    input  frame_idx_t  rd_idx_i,
    output frac_t       rd_frac_o,
    output frame_idx_t  frame_len_o,
    output logic        frame_ready_o
);

    frac_t          frac_mem [`FRAME_DEPTH];
    frame_idx_t     wr_cnt;

    always_ff @(posedge clock_i)
    begin
        if (lut_valid_i && (wr_cnt < `FRAME_DEPTH))
        begin
            frac_mem[wr_cnt] <= lut_frac_i;
        end
    end

    always_ff @(posedge clock_i)
    begin
        if (!reset_n_i || frame_clear_i)
        begin
            wr_cnt        <= '0;
            frame_len_o   <= '0;
            frame_ready_o <= 1'b0;
        end
        else
        begin
            if (lut_valid_i && (wr_cnt < `FRAME_DEPTH))
            begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (lut_done_i)
            begin
                frame_len_o   <= wr_cnt + frame_idx_t'(lut_valid_i); // last sample may share the cycle
                frame_ready_o <= 1'b1;
            end
        end
    end

    assign rd_frac_o = frac_mem[rd_idx_i];

endmodule

/* src/exp_lut_pipe.sv */
`timescale 1ns/100ps
`include "exp_cfg.svh"

module exp_lut_pipe
    import exp_pkg::*;
(
    input  logic        clock_i,
    input  logic        reset_n_i,
    input  exp_in_t     sample_i,           // negative, 1.7.8
    input  logic        sample_valid_i,
    input  logic        frame_done_i,
    output frac_t       lut_frac_o,
    output logic        lut_valid_o,
    output logic        lut_done_o
);

    // e^-(2^(b-8)) in 0.16, indexed by magnitude bit b
    localparam frac_t EXP_LUT [0:`EXP_LUT_N-1] = '{
        16'hFF00,   // 2^-8
        16'hFE01,
        16'hFC07,
        16'hF81F,
        16'hF07D,
        16'hE1EB,
        16'hC75F,
        16'h9B45,   // 2^-1
        16'h5E2D,   // 2^0
        16'h22A5,
        16'h04B0,
        16'h0015    // 2^3
    };

    exp_in_t                    mag;
    logic                       too_big;
    prod_t                      prod_init;
    prod_t                      prod_q  [`EXP_LUT_N];
    logic [`EXP_LUT_N-1:0]      mag_q   [`EXP_LUT_N-1];
    logic [`EXP_LUT_N-1:0]      valid_q;
    logic [`EXP_LUT_N-1:0]      done_q;

    // one table product, upper half kept
    function automatic prod_t lut_step(prod_t p, logic use_bit, frac_t c);
        logic [2*`EXP_PROD_W-1:0] full;
        full = p * {c, {(`EXP_PROD_W-`EXP_FRAC_W){1'b0}}};
        return use_bit ? full[2*`EXP_PROD_W-1:`EXP_PROD_W] : p;
    endfunction

    assign mag     = ~sample_i + 1'b1;                      // magnitude of the sample
    assign too_big = |mag[`EXP_IN_W-2:`EXP_LUT_N];          // 16.0 and up underflows

    // a zero magnitude passes all ones through untouched
    assign prod_init = too_big ? '0 :
                       {{`EXP_FRAC_W{1'b1}}, {(`EXP_PROD_W-`EXP_FRAC_W){1'b0}}};

    always_ff @(posedge clock_i)
    begin
        prod_q[0] <= lut_step(prod_init, mag[`EXP_LUT_N-1], EXP_LUT[`EXP_LUT_N-1]);
        mag_q[0]  <= mag[`EXP_LUT_N-1:0];
        for (int s = 1; s < `EXP_LUT_N; s++)
        begin
            prod_q[s] <= lut_step(prod_q[s-1], mag_q[s-1][`EXP_LUT_N-1-s],
                                  EXP_LUT[`EXP_LUT_N-1-s]);
            if (s < `EXP_LUT_N-1)
            begin
                mag_q[s] <= mag_q[s-1];
            end
        end
    end

    // valid and done ride along with the data
    always_ff @(posedge clock_i)
    begin
        if (!reset_n_i)
        begin
            valid_q <= '0;
            done_q  <= '0;
        end
        else
        begin
            valid_q <= {valid_q[`EXP_LUT_N-2:0], sample_valid_i};
            done_q  <= {done_q[`EXP_LUT_N-2:0], frame_done_i};
        end
    end

    assign lut_frac_o  = prod_q[`EXP_LUT_N-1][`EXP_PROD_W-1 -: `EXP_FRAC_W];
    assign lut_valid_o = valid_q[`EXP_LUT_N-1];
    assign lut_done_o  = done_q[`EXP_LUT_N-1];

endmodule

/* src/exp_pkg.sv */
`include "exp_cfg.svh"

package exp_pkg;

    typedef logic [`EXP_IN_W-1:0]       exp_in_t;       // 1.7.8 sample
    typedef logic [`EXP_FRAC_W-1:0]     frac_t;         // 0.16 result
    typedef logic [`EXP_PROD_W-1:0]     prod_t;         // running product
    typedef logic [`FP_W-1:0]           fp32_t;
    typedef logic [`FRAME_IDX_W-1:0]    frame_idx_t;    // 0 .. FRAME_DEPTH

    // fixed to float normalizer
    typedef enum logic [1:0]
    {
        CVT_IDLE,
        CVT_LOAD,
        CVT_SHIFT,
        CVT_WRITE
    } cvt_state_t;

    // stream output
    typedef enum logic [1:0]
    {
        OUT_IDLE,
        OUT_SEND,
        OUT_DONE
    } out_state_t;

endpackage

/* src/exp_cfg.svh */
`ifndef EXP_CFG_SVH
`define EXP_CFG_SVH

// input sample, 1.7.8 two's complement
`define EXP_IN_W        16

// e^-x result, unsigned 0.16
`define EXP_FRAC_W      16

// running product inside the evaluator
`define EXP_PROD_W      32

// single precision word
`define FP_W            32

// samples per frame at most
`define FRAME_DEPTH     10

// wide enough to count 0 .. FRAME_DEPTH
`define FRAME_IDX_W     4

// table entries, one pipeline stage each
`define EXP_LUT_N       12

// biased exponent of a fraction with its top bit set
`define FP_EXP_START    8'd126

`endif
